// ==== src/lsu_pkg.sv ====
package lsu_pkg;

    // Memory geometry
    localparam int MEM_WORDS = 256;
    localparam int MEM_ADDR_W = 8;

    // Store buffer geometry
    localparam int STORE_BUFFER_DEPTH = 4;
    localparam int STORE_BUFFER_PTR_W = $clog2(STORE_BUFFER_DEPTH);

    // Trap codes reported to the commit stage
    localparam logic [4:0] TRAP_NONE = 5'd0;
    localparam logic [4:0] TRAP_ILLEGAL_MEMORY_ACCESS = 5'd7;

    typedef logic [31:0] data_word_t;

    // One word seen whole, as halfword lanes or as byte lanes
    typedef union packed {
        data_word_t word;
        logic [1:0][15:0] half;
        logic [3:0][7:0] lane;
    } data_word_u;

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU
    } ldu_uop_t;

    typedef enum logic [1:0] {
        SB,
        SH,
        SW
    } stu_uop_t;

    typedef struct packed {
        logic [3:0] rob_tag;
        logic [4:0] reg_dest;
        logic [4:0] trap_vector;
    } instr_packet_t;

    typedef struct packed {
        logic [MEM_ADDR_W - 1:0] word_address;
        data_word_t data;
        logic [3:0] byte_enable;
    } store_buffer_entry_t;

endpackage : lsu_pkg

// ==== src/load_unit.sv ====
`timescale 1ns/1ps

module load_unit import lsu_pkg::*; (
    input logic clk_i,
    input logic reset_i,
    input logic valid_i,
    input data_word_t address_i,
    input ldu_uop_t operation_i,
    input logic accepted_i,
    input logic address_match_i,
    input data_word_t read_data_i,
    input logic read_valid_i,
    output logic [MEM_ADDR_W - 1:0] match_address_o,
    output logic read_req_o,
    output logic [MEM_ADDR_W - 1:0] read_address_o,
    output data_word_t loaded_data_o,
    output logic data_valid_o,
    output logic idle_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_HAZARD,
        WAIT_DATA,
        HOLD
    } state_t;

    state_t state;
    data_word_t address_q;
    ldu_uop_t operation_q;
    data_word_t extended;
    data_word_u raw;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (valid_i) state <= WAIT_HAZARD;
                WAIT_HAZARD: if (!address_match_i) state <= WAIT_DATA;
                WAIT_DATA: if (read_valid_i) state <= HOLD;
                HOLD: if (accepted_i) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Request fields are captured on the issue strobe
    always_ff @(posedge clk_i) begin
        if (state == IDLE && valid_i) begin
            address_q <= address_i;
            operation_q <= operation_i;
        end
    end

    assign raw = read_data_i;

    // Pick the lane from the low address bits, then extend
    always_comb begin
        case (operation_q)
            LB: extended = {{24{raw.lane[address_q[1:0]][7]}}, raw.lane[address_q[1:0]]};
            LBU: extended = {24'b0, raw.lane[address_q[1:0]]};
            LH: extended = {{16{raw.half[address_q[1]][15]}}, raw.half[address_q[1]]};
            LHU: extended = {16'b0, raw.half[address_q[1]]};
            default: extended = raw.word;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (state == WAIT_DATA && read_valid_i) begin
            loaded_data_o <= extended;
        end
    end

    // The read goes out only once no buffered store hits this word
    assign match_address_o = address_q[MEM_ADDR_W + 1:2];
    assign read_address_o = address_q[MEM_ADDR_W + 1:2];
    assign read_req_o = (state == WAIT_HAZARD) && !address_match_i;
    assign data_valid_o = (state == HOLD);
    assign idle_o = (state == IDLE);

endmodule : load_unit

// ==== src/store_unit.sv ====
`timescale 1ns/1ps

module store_unit import lsu_pkg::*; (
    input logic clk_i,
    input logic reset_i,
    input logic valid_i,
    input data_word_t address_i,
    input data_word_t data_i,
    input stu_uop_t operation_i,
    input logic accepted_i,
    input logic full_i,
    output logic push_o,
    output store_buffer_entry_t entry_o,
    output logic illegal_access_o,
    output logic data_valid_o,
    output logic idle_o
);

    typedef enum logic [1:0] {
        IDLE,
        PUSH,
        HOLD
    } state_t;

    state_t state;
    data_word_t address_q;
    data_word_t data_q;
    stu_uop_t operation_q;
    data_word_u placed;
    logic misaligned;
    logic done;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (valid_i) state <= PUSH;
                PUSH: if (done) state <= accepted_i ? IDLE : HOLD;
                HOLD: if (accepted_i) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == IDLE && valid_i) begin
            address_q <= address_i;
            data_q <= data_i;
            operation_q <= operation_i;
        end
    end

    // Alignment depends on the access width
    always_comb begin
        case (operation_q)
            SB: misaligned = 1'b0;
            SH: misaligned = address_q[0];
            default: misaligned = |address_q[1:0];
        endcase
    end

    assign illegal_access_o = misaligned || (address_q >= MEM_WORDS * 4);

    // Replicate data so every candidate lane holds it, the mask picks one
    always_comb begin
        case (operation_q)
            SB: begin
                placed.lane = {4{data_q[7:0]}};
                entry_o.byte_enable = 4'b0001 << address_q[1:0];
            end
            SH: begin
                placed.half = {2{data_q[15:0]}};
                entry_o.byte_enable = 4'b0011 << {address_q[1], 1'b0};
            end
            default: begin
                placed.word = data_q;
                entry_o.byte_enable = 4'b1111;
            end
        endcase
        entry_o.word_address = address_q[MEM_ADDR_W + 1:2];
        entry_o.data = placed.word;
    end

    // An illegal store completes without touching the buffer
    assign done = (state == PUSH) && (illegal_access_o || !full_i);
    assign push_o = (state == PUSH) && !illegal_access_o && !full_i;
    assign data_valid_o = done || (state == HOLD);
    assign idle_o = (state == IDLE);

endmodule : store_unit

// ==== src/store_buffer.sv ====
`timescale 1ns/1ps

module store_buffer import lsu_pkg::*; (
    input logic clk_i,
    input logic reset_i,
    input logic push_i,
    input store_buffer_entry_t entry_i,
    input logic [MEM_ADDR_W - 1:0] match_address_i,
    output logic full_o,
    output logic address_match_o,
    output logic write_en_o,
    output store_buffer_entry_t write_entry_o
);

    store_buffer_entry_t entries [STORE_BUFFER_DEPTH];
    logic [STORE_BUFFER_DEPTH - 1:0] valid;
    logic [STORE_BUFFER_PTR_W - 1:0] head;
    logic [STORE_BUFFER_PTR_W - 1:0] tail;
    logic pop;

    // The head drains every cycle the buffer holds something
    assign pop = |valid;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            // Push and pop never hit the same slot, a full buffer refuses pushes
            if (push_i) begin
                valid[tail] <= 1'b1;
                tail <= tail + 1'b1;
            end
            if (pop) begin
                valid[head] <= 1'b0;
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            entries[tail] <= entry_i;
        end
    end

    // Any live entry on the load's word blocks the load
    always_comb begin
        address_match_o = 1'b0;
        for (int i = 0; i < STORE_BUFFER_DEPTH; i++) begin
            if (valid[i] && entries[i].word_address == match_address_i) begin
                address_match_o = 1'b1;
            end
        end
    end

    assign full_o = &valid;
    assign write_en_o = pop;
    assign write_entry_o = entries[head];

endmodule : store_buffer

// ==== src/data_memory.sv ====
`timescale 1ns/1ps

module data_memory import lsu_pkg::*; (
    input logic clk_i,
    input logic read_req_i,
    input logic [MEM_ADDR_W - 1:0] read_address_i,
    input logic write_en_i,
    input store_buffer_entry_t write_entry_i,
    output data_word_t read_data_o,
    output logic read_valid_o
);

    data_word_t mem [MEM_WORDS];

    // Byte lanes are written only where the mask is set
    always_ff @(posedge clk_i) begin
        if (write_en_i) begin
            for (int i = 0; i < 4; i++) begin
                if (write_entry_i.byte_enable[i]) begin
                    mem[write_entry_i.word_address][i * 8 +: 8] <= write_entry_i.data[i * 8 +: 8];
                end
            end
        end
    end

    // Registered read sees the word as it was before this cycle's write
    always_ff @(posedge clk_i) begin
        if (read_req_i) begin
            read_data_o <= mem[read_address_i];
        end
        read_valid_o <= read_req_i;
    end

endmodule : data_memory

// ==== src/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit import lsu_pkg::*; (
    input logic clk_i,
    input logic reset_i,
    input instr_packet_t instr_packet_i,
    input logic ldu_valid_i,
    input data_word_t ldu_address_i,
    input ldu_uop_t ldu_operation_i,
    output logic ldu_idle_o,
    input logic stu_valid_i,
    input data_word_t stu_data_i,
    input data_word_t stu_address_i,
    input stu_uop_t stu_operation_i,
    output logic stu_idle_o,
    input logic str_buf_full_i,
    input logic str_buf_address_match_i,
    output logic str_buf_push_o,
    output store_buffer_entry_t str_buf_entry_o,
    output logic [MEM_ADDR_W - 1:0] str_buf_match_address_o,
    output logic mem_read_req_o,
    output logic [MEM_ADDR_W - 1:0] mem_read_address_o,
    input data_word_t mem_read_data_i,
    input logic mem_read_valid_i,
    output instr_packet_t instr_packet_o,
    output data_word_t data_o,
    output logic data_valid_o
);

    logic ldu_data_valid;
    logic ldu_accepted;
    data_word_t ldu_loaded_data;
    logic stu_data_valid;
    logic stu_accepted;
    logic stu_illegal_access;
    instr_packet_t ldu_ipacket;
    instr_packet_t stu_ipacket;
    instr_packet_t stu_result_packet;

    load_unit u_load_unit (
        .clk_i           ( clk_i                   ),
        .reset_i         ( reset_i                 ),
        .valid_i         ( ldu_valid_i             ),
        .address_i       ( ldu_address_i           ),
        .operation_i     ( ldu_operation_i         ),
        .accepted_i      ( ldu_accepted            ),
        .address_match_i ( str_buf_address_match_i ),
        .read_data_i     ( mem_read_data_i         ),
        .read_valid_i    ( mem_read_valid_i        ),
        .match_address_o ( str_buf_match_address_o ),
        .read_req_o      ( mem_read_req_o          ),
        .read_address_o  ( mem_read_address_o      ),
        .loaded_data_o   ( ldu_loaded_data         ),
        .data_valid_o    ( ldu_data_valid          ),
        .idle_o          ( ldu_idle_o              )
    );

    store_unit u_store_unit (
        .clk_i            ( clk_i              ),
        .reset_i          ( reset_i            ),
        .valid_i          ( stu_valid_i        ),
        .address_i        ( stu_address_i      ),
        .data_i           ( stu_data_i         ),
        .operation_i      ( stu_operation_i    ),
        .accepted_i       ( stu_accepted       ),
        .full_i           ( str_buf_full_i     ),
        .push_o           ( str_buf_push_o     ),
        .entry_o          ( str_buf_entry_o    ),
        .illegal_access_o ( stu_illegal_access ),
        .data_valid_o     ( stu_data_valid     ),
        .idle_o           ( stu_idle_o         )
    );

    // Packets follow their instruction from issue to commit
    always_ff @(posedge clk_i) begin
        if (ldu_idle_o && ldu_valid_i) begin
            ldu_ipacket <= instr_packet_i;
        end
        if (stu_idle_o && stu_valid_i) begin
            stu_ipacket <= instr_packet_i;
        end
    end

    always_comb begin
        stu_result_packet = stu_ipacket;
        if (stu_illegal_access) begin
            stu_result_packet.trap_vector = TRAP_ILLEGAL_MEMORY_ACCESS;
        end
    end

    // Loads win, a store result waits for a free slot
    always_comb begin
        ldu_accepted = 1'b0;
        stu_accepted = 1'b0;
        instr_packet_o = '{rob_tag: '0, reg_dest: '0, trap_vector: TRAP_NONE};
        data_o = '0;
        if (ldu_data_valid) begin
            ldu_accepted = 1'b1;
            instr_packet_o = ldu_ipacket;
            data_o = ldu_loaded_data;
        end else if (stu_data_valid) begin
            stu_accepted = 1'b1;
            instr_packet_o = stu_result_packet;
        end
    end

    assign data_valid_o = ldu_data_valid | stu_data_valid;

endmodule : load_store_unit

// ==== src/memory_subsystem.sv ====
`timescale 1ns/1ps

module memory_subsystem import lsu_pkg::*; (
    input logic clk_i,
    input logic reset_i,
    input instr_packet_t instr_packet_i,
    input logic ldu_valid_i,
    input data_word_t ldu_address_i,
    input ldu_uop_t ldu_operation_i,
    output logic ldu_idle_o,
    input logic stu_valid_i,
    input data_word_t stu_data_i,
    input data_word_t stu_address_i,
    input stu_uop_t stu_operation_i,
    output logic stu_idle_o,
    output instr_packet_t instr_packet_o,
    output data_word_t data_o,
    output logic data_valid_o
);

    logic str_buf_full;
    logic str_buf_address_match;
    logic str_buf_push;
    store_buffer_entry_t str_buf_entry;
    logic [MEM_ADDR_W - 1:0] str_buf_match_address;
    logic mem_read_req;
    logic [MEM_ADDR_W - 1:0] mem_read_address;
    data_word_t mem_read_data;
    logic mem_read_valid;
    logic mem_write_en;
    store_buffer_entry_t mem_write_entry;

    load_store_unit u_load_store_unit (
        .clk_i                   ( clk_i                 ),
        .reset_i                 ( reset_i               ),
        .instr_packet_i          ( instr_packet_i        ),
        .ldu_valid_i             ( ldu_valid_i           ),
        .ldu_address_i           ( ldu_address_i         ),
        .ldu_operation_i         ( ldu_operation_i       ),
        .ldu_idle_o              ( ldu_idle_o            ),
        .stu_valid_i             ( stu_valid_i           ),
        .stu_data_i              ( stu_data_i            ),
        .stu_address_i           ( stu_address_i         ),
        .stu_operation_i         ( stu_operation_i       ),
        .stu_idle_o              ( stu_idle_o            ),
        .str_buf_full_i          ( str_buf_full          ),
        .str_buf_address_match_i ( str_buf_address_match ),
        .str_buf_push_o          ( str_buf_push          ),
        .str_buf_entry_o         ( str_buf_entry         ),
        .str_buf_match_address_o ( str_buf_match_address ),
        .mem_read_req_o          ( mem_read_req          ),
        .mem_read_address_o      ( mem_read_address      ),
        .mem_read_data_i         ( mem_read_data         ),
        .mem_read_valid_i        ( mem_read_valid        ),
        .instr_packet_o          ( instr_packet_o        ),
        .data_o                  ( data_o                ),
        .data_valid_o            ( data_valid_o          )
    );

    store_buffer u_store_buffer (
        .clk_i           ( clk_i                 ),
        .reset_i         ( reset_i               ),
        .push_i          ( str_buf_push          ),
        .entry_i         ( str_buf_entry         ),
        .match_address_i ( str_buf_match_address ),
        .full_o          ( str_buf_full          ),
        .address_match_o ( str_buf_address_match ),
        .write_en_o      ( mem_write_en          ),
        .write_entry_o   ( mem_write_entry       )
    );

    data_memory u_data_memory (
        .clk_i          ( clk_i            ),
        .read_req_i     ( mem_read_req     ),
        .read_address_i ( mem_read_address ),
        .write_en_i     ( mem_write_en     ),
        .write_entry_i  ( mem_write_entry  ),
        .read_data_o    ( mem_read_data    ),
        .read_valid_o   ( mem_read_valid   )
    );

endmodule : memory_subsystem

// ==== test/tb_memory_subsystem.sv ====
`timescale 1ns/1ps

module tb_memory_subsystem import lsu_pkg::*; ();

    logic clk_i;
    logic reset_i;
    instr_packet_t instr_packet_i;
    logic ldu_valid_i;
    data_word_t ldu_address_i;
    ldu_uop_t ldu_operation_i;
    logic ldu_idle_o;
    logic stu_valid_i;
    data_word_t stu_data_i;
    data_word_t stu_address_i;
    stu_uop_t stu_operation_i;
    logic stu_idle_o;
    instr_packet_t instr_packet_o;
    data_word_t data_o;
    logic data_valid_o;

    logic [7:0] model [MEM_WORDS * 4];
    instr_packet_t got_pkt_q[$];
    data_word_t got_data_q[$];
    instr_packet_t exp_pkt_q[$];
    data_word_t exp_data_q[$];
    int issued = 0;
    int cycles = 0;
    logic [3:0] next_tag = 4'd0;
    integer seed = 32'hfe910494;

    memory_subsystem u_dut (
        .clk_i           ( clk_i           ),
        .reset_i         ( reset_i         ),
        .instr_packet_i  ( instr_packet_i  ),
        .ldu_valid_i     ( ldu_valid_i     ),
        .ldu_address_i   ( ldu_address_i   ),
        .ldu_operation_i ( ldu_operation_i ),
        .ldu_idle_o      ( ldu_idle_o      ),
        .stu_valid_i     ( stu_valid_i     ),
        .stu_data_i      ( stu_data_i      ),
        .stu_address_i   ( stu_address_i   ),
        .stu_operation_i ( stu_operation_i ),
        .stu_idle_o      ( stu_idle_o      ),
        .instr_packet_o  ( instr_packet_o  ),
        .data_o          ( data_o          ),
        .data_valid_o    ( data_valid_o    )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    // Every committed result is collected where outputs are settled
    always @(negedge clk_i) begin
        cycles <= cycles + 1;
        if (!reset_i && data_valid_o) begin
            got_pkt_q.push_back(instr_packet_o);
            got_data_q.push_back(data_o);
        end
    end

    always @(posedge clk_i) begin
        if (cycles > 200 * (issued + 1) + 20) begin
            abort_run("Simulation timed out waiting for a result");
        end
    end

    task automatic compare_packet(input string name, input instr_packet_t exp,
                                  input instr_packet_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s packet expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_data(input string name, input data_word_t exp,
                                input data_word_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s data expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic instr_packet_t new_packet(input logic [4:0] trap);
        instr_packet_t p;
        p.rob_tag = next_tag;
        p.reg_dest = {1'b0, next_tag} + 5'd1;
        p.trap_vector = trap;
        return p;
    endfunction

    // Expected load value built from the byte model and the extension rules
    function automatic data_word_t expected_load(input data_word_t a, input ldu_uop_t op);
        logic [15:0] h;
        h = {model[a + 1], model[a]};
        case (op)
            LB: return {{24{model[a][7]}}, model[a]};
            LBU: return {24'b0, model[a]};
            LH: return {{16{h[15]}}, h};
            LHU: return {16'b0, h};
            default: return {model[a + 3], model[a + 2], h};
        endcase
    endfunction

    function automatic logic store_is_illegal(input data_word_t a, input stu_uop_t op);
        if (a >= MEM_WORDS * 4) return 1'b1;
        if (op == SH) return a[0];
        if (op == SW) return |a[1:0];
        return 1'b0;
    endfunction

    task automatic expect_store(input data_word_t a, input data_word_t d, input stu_uop_t op);
        logic bad;
        bad = store_is_illegal(a, op);
        exp_pkt_q.push_back(new_packet(bad ? TRAP_ILLEGAL_MEMORY_ACCESS : TRAP_NONE));
        exp_data_q.push_back('0);
        if (!bad) begin
            model[a] = d[7:0];
            if (op != SB) model[a + 1] = d[15:8];
            if (op == SW) begin
                model[a + 2] = d[23:16];
                model[a + 3] = d[31:24];
            end
        end
        issued++;
    endtask

    task automatic drive_store(input data_word_t a, input data_word_t d, input stu_uop_t op);
        instr_packet_i <= new_packet(TRAP_NONE);
        stu_valid_i <= 1'b1;
        stu_address_i <= a;
        stu_data_i <= d;
        stu_operation_i <= op;
        expect_store(a, d, op);
        next_tag = next_tag + 4'd1;
    endtask

    task automatic drive_load(input data_word_t a, input ldu_uop_t op);
        instr_packet_i <= new_packet(TRAP_NONE);
        ldu_valid_i <= 1'b1;
        ldu_address_i <= a;
        ldu_operation_i <= op;
        exp_pkt_q.push_back(new_packet(TRAP_NONE));
        exp_data_q.push_back(expected_load(a, op));
        issued++;
        next_tag = next_tag + 4'd1;
    endtask

    task automatic issue_store(input data_word_t a, input data_word_t d, input stu_uop_t op);
        @(negedge clk_i);
        while (!stu_idle_o) @(negedge clk_i);
        @(posedge clk_i);
        drive_store(a, d, op);
        @(posedge clk_i);
        stu_valid_i <= 1'b0;
    endtask

    task automatic issue_load(input data_word_t a, input ldu_uop_t op);
        @(negedge clk_i);
        while (!ldu_idle_o) @(negedge clk_i);
        @(posedge clk_i);
        drive_load(a, op);
        @(posedge clk_i);
        ldu_valid_i <= 1'b0;
    endtask

    // Results must arrive in the order the requests were issued
    task automatic check_results(input string name);
        while (got_pkt_q.size() < exp_pkt_q.size()) @(negedge clk_i);
        while (exp_pkt_q.size() > 0) begin
            compare_packet(name, exp_pkt_q.pop_front(), got_pkt_q.pop_front());
            compare_data(name, exp_data_q.pop_front(), got_data_q.pop_front());
        end
    endtask

    // Both units idle and nothing committed once reset is released
    task automatic reset_state();
        @(negedge clk_i);
        compare_flag("reset_state load idle", 1'b1, ldu_idle_o);
        compare_flag("reset_state store idle", 1'b1, stu_idle_o);
        compare_flag("reset_state data valid", 1'b0, data_valid_o);
    endtask

    task automatic store_then_load();
        @(negedge clk_i);
        while (!stu_idle_o || !ldu_idle_o) @(negedge clk_i);
        @(posedge clk_i);
        drive_store(32'h100, 32'hdeadbeef, SW);
        @(posedge clk_i);
        stu_valid_i <= 1'b0;
        drive_load(32'h100, LW);
        @(posedge clk_i);
        ldu_valid_i <= 1'b0;
        check_results("store_then_load");
    endtask

    task automatic sub_word_stores();
        issue_store(32'h200, 32'h11223344, SW);
        issue_store(32'h201, 32'h000000a5, SB);
        issue_store(32'h202, 32'h00008001, SH);
        issue_load(32'h200, LW);
        check_results("sub_word_stores");
    endtask

    task automatic load_extension();
        issue_store(32'h300, 32'h80ff7f01, SW);
        for (int i = 0; i < 4; i++) begin
            issue_load(32'h300 + i, LB);
            issue_load(32'h300 + i, LBU);
        end
        issue_load(32'h300, LH);
        issue_load(32'h302, LH);
        issue_load(32'h300, LHU);
        issue_load(32'h302, LHU);
        check_results("load_extension");
    endtask

    // Word 0 is where an out-of-range word address would wrap to
    task automatic illegal_store();
        issue_store(32'h000, 32'h0badf00d, SW);
        issue_store(32'h101, 32'h0000ffff, SH);
        issue_store(32'h400, 32'h12345678, SW);
        issue_load(32'h100, LW);
        issue_load(32'h000, LW);
        check_results("illegal_store");
    endtask

    // The store strobe lands two cycles after the load so both results coincide
    task automatic load_priority();
        issue_store(32'h340, 32'hcafe0123, SW);
        check_results("load_priority");
        issue_load(32'h340, LW);
        issue_store(32'h380, 32'h55aa55aa, SW);
        check_results("load_priority");
        repeat (10) @(posedge clk_i);
        if (got_pkt_q.size() != 0) begin
            abort_run("load_priority produced an extra result");
        end
    endtask

    task automatic random_mix();
        data_word_t a;
        for (int w = 0; w < 16; w++) begin
            issue_store(32'h080 + 4 * w, $random(seed), SW);
        end
        for (int n = 0; n < 40; n++) begin
            a = 32'h080 + ($unsigned($random(seed)) % 64);
            case ($unsigned($random(seed)) % 6)
                0: issue_store(a, $random(seed), SB);
                1: issue_store({a[31:1], 1'b0}, $random(seed), SH);
                2: issue_store({a[31:2], 2'b0}, $random(seed), SW);
                3: issue_load(a, $random(seed) & 1 ? LB : LBU);
                4: issue_load({a[31:1], 1'b0}, $random(seed) & 1 ? LH : LHU);
                default: issue_load({a[31:2], 2'b0}, LW);
            endcase
        end
        check_results("random_mix");
    endtask

    initial begin
        reset_i = 1'b1;
        instr_packet_i = '0;
        ldu_valid_i = 1'b0;
        ldu_address_i = '0;
        ldu_operation_i = LW;
        stu_valid_i = 1'b0;
        stu_data_i = '0;
        stu_address_i = '0;
        stu_operation_i = SW;
        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;
        reset_state();
        store_then_load();
        sub_word_stores();
        load_extension();
        illegal_store();
        load_priority();
        random_mix();
        repeat (5) @(posedge clk_i);
        if (got_pkt_q.size() != 0) begin
            $display("Unexpected results remained after the last test");
            $display("Test failures found");
            $fatal(1);
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule : tb_memory_subsystem

// ==== filelist.f ====
src/lsu_pkg.sv
src/load_unit.sv
src/store_unit.sv
src/store_buffer.sv
src/data_memory.sv
src/load_store_unit.sv
src/memory_subsystem.sv
test/tb_memory_subsystem.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f filelist.f --top-module tb_memory_subsystem -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }
